//--- hw/tagger_pkg.sv
package tagger_pkg;

    // Field widths of the raw tag word
    localparam int CHAN_W    = 5;
    localparam int SUBTIME_W = 26;
    localparam int TAGTIME_W = 64;

    // Reserved channel codes, never counted as event channels
    localparam logic [CHAN_W-1:0] WRAP_CODE     = 5'd31;
    localparam logic [CHAN_W-1:0] OVERFLOW_CODE = 5'd30;

    // Raw word as it leaves the link decoder
    typedef struct packed {
        logic [CHAN_W-1:0]    channel;
        logic                 rising;
        logic [SUBTIME_W-1:0] subtime;
    } tag_word_t;

    // Kinds of words that go past the decoder
    typedef enum logic [1:0] {
        KIND_EVENT = 2'd0,
        KIND_WRAP  = 2'd1
    } tag_kind_t;

    // Decoder output, 34 bits
    typedef struct packed {
        tag_kind_t            kind;
        logic [CHAN_W-1:0]    channel;
        logic                 rising;
        logic [SUBTIME_W-1:0] subtime;
    } decoded_tag_t;

    // Extender output, 70 bits
    typedef struct packed {
        logic [CHAN_W-1:0]    channel;
        logic                 rising;
        logic [TAGTIME_W-1:0] tagtime;
    } timed_tag_t;

endpackage

//--- hw/pipe_stage.sv
`timescale 1ns/1ns

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     sys_clk,
    input  logic     sys_clk_rst,

    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,

    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     full_q;
    payload_t data_q;

    // Take a new beat when empty or when the held beat leaves now
    assign in_ready_o = !full_q || out_ready_i;

    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            full_q <= 1'b0;
        end else if (in_ready_o) begin
            full_q <= in_valid_i;
        end
    end

    // Payload register only loads on an input handshake
    always_ff @(posedge sys_clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

endmodule

//--- hw/tag_decoder.sv
`timescale 1ns/1ns

module tag_decoder #(
    parameter int NUM_CHANNELS = 8
) (
    input  logic                     sys_clk,
    input  logic                     sys_clk_rst,

    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  tagger_pkg::tag_word_t    in_word_i,

    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output tagger_pkg::decoded_tag_t out_tag_o,

    output logic                     overflow_o,
    output logic [15:0]              invalid_count_o
);

    logic        is_wrap;
    logic        is_overflow;
    logic        is_invalid;
    logic        forward;
    logic        accept;
    logic        overflow_q;
    logic [15:0] invalid_count_q;

    // Classify by channel code
    always_comb begin
        is_wrap     = in_word_i.channel == tagger_pkg::WRAP_CODE;
        is_overflow = in_word_i.channel == tagger_pkg::OVERFLOW_CODE;
        is_invalid  = !is_wrap && !is_overflow &&
                      (int'(in_word_i.channel) >= NUM_CHANNELS);
        forward     = !is_overflow && !is_invalid;
    end

    // Dropped words are swallowed here, so downstream is not involved
    assign in_ready_o  = forward ? out_ready_i : 1'b1;
    assign out_valid_o = in_valid_i && forward;
    assign accept      = in_valid_i && in_ready_o;

    always_comb begin
        out_tag_o.kind    = is_wrap ? tagger_pkg::KIND_WRAP : tagger_pkg::KIND_EVENT;
        out_tag_o.channel = in_word_i.channel;
        out_tag_o.rising  = in_word_i.rising;
        out_tag_o.subtime = in_word_i.subtime;
    end

    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            overflow_q      <= 1'b0;
            invalid_count_q <= '0;
        end else if (accept) begin
            // Sticky until the next reset
            if (is_overflow) begin
                overflow_q <= 1'b1;
            end
            // Saturates at all ones
            if (is_invalid && invalid_count_q != '1) begin
                invalid_count_q <= invalid_count_q + 16'd1;
            end
        end
    end

    assign overflow_o      = overflow_q;
    assign invalid_count_o = invalid_count_q;

endmodule

//--- hw/tag_time_extender.sv
`timescale 1ns/1ns

module tag_time_extender (
    input  logic                     sys_clk,
    input  logic                     sys_clk_rst,

    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  tagger_pkg::decoded_tag_t in_tag_i,

    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output tagger_pkg::timed_tag_t   out_tag_o
);

    // Wrap count fills the tagtime bits above the subtime
    localparam int WRAP_W = tagger_pkg::TAGTIME_W - tagger_pkg::SUBTIME_W;

    logic              is_wrap;
    logic [WRAP_W-1:0] wrap_cnt_q;

    assign is_wrap = in_tag_i.kind == tagger_pkg::KIND_WRAP;

    // Wrap words end here and never wait on downstream
    assign in_ready_o  = is_wrap ? 1'b1 : out_ready_i;
    assign out_valid_o = in_valid_i && !is_wrap;

    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            wrap_cnt_q <= '0;
        end else if (in_valid_i && is_wrap) begin
            wrap_cnt_q <= wrap_cnt_q + 1'b1;
        end
    end

    // Event time is wrap count times 2^SUBTIME_W plus subtime
    always_comb begin
        out_tag_o.channel = in_tag_i.channel;
        out_tag_o.rising  = in_tag_i.rising;
        out_tag_o.tagtime = {wrap_cnt_q, in_tag_i.subtime};
    end

endmodule

//--- hw/channel_counters.sv
`timescale 1ns/1ns

module channel_counters #(
    parameter int NUM_CHANNELS = 8,
    parameter int CNT_W        = 16
) (
    input  logic                          sys_clk,
    input  logic                          sys_clk_rst,

    // Output handshake of the event stream
    input  logic                          evt_valid_i,
    input  logic [tagger_pkg::CHAN_W-1:0] evt_channel_i,
    input  logic                          evt_rising_i,

    input  logic                          clear_i,
    input  logic [tagger_pkg::CHAN_W-1:0] rd_addr_i,
    output logic [CNT_W-1:0]              rd_data_o
);

    logic [CNT_W-1:0] cnt_q [NUM_CHANNELS];
    logic [CNT_W-1:0] rd_mux;
    logic [CNT_W-1:0] rd_data_q;

    // One wrapping counter per channel
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst || clear_i) begin
            // Clear wins over a count on the same edge
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                cnt_q[i] <= '0;
            end
        end else if (evt_valid_i && evt_rising_i) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                if (int'(evt_channel_i) == i) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    // Addresses past the last channel fall through to zero
    always_comb begin
        rd_mux = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (int'(rd_addr_i) == i) begin
                rd_mux = cnt_q[i];
            end
        end
    end

    // Read data one cycle after the address
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            rd_data_q <= '0;
        end else begin
            rd_data_q <= rd_mux;
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

//--- hw/tag_pipeline_top.sv
`timescale 1ns/1ns

module tag_pipeline_top #(
    parameter int NUM_CHANNELS = 8,
    parameter int CNT_W        = 16
) (
    input  logic             sys_clk,
    input  logic             sys_clk_rst,

    // Raw tag words from the link decoder
    input  logic             s_valid_i,
    output logic             s_ready_o,
    input  logic [31:0]      s_data_i,

    // Timed events
    output logic             m_valid_o,
    input  logic             m_ready_i,
    output logic [4:0]       m_channel_o,
    output logic             m_rising_o,
    output logic [63:0]      m_tagtime_o,

    // Counter read port
    input  logic [4:0]       cnt_addr_i,
    input  logic             cnt_clear_i,
    output logic [CNT_W-1:0] cnt_data_o,

    output logic             overflow_o,
    output logic [15:0]      invalid_count_o
);

    logic                     dec_valid;
    logic                     dec_ready;
    tagger_pkg::decoded_tag_t dec_tag;

    logic                     ext_in_valid;
    logic                     ext_in_ready;
    tagger_pkg::decoded_tag_t ext_in_tag;

    logic                     ext_valid;
    logic                     ext_ready;
    tagger_pkg::timed_tag_t   ext_tag;

    tagger_pkg::timed_tag_t   out_tag;
    logic                     out_fire;

    tag_decoder #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) tag_decoder_inst (
        .sys_clk         (sys_clk),
        .sys_clk_rst     (sys_clk_rst),
        .in_valid_i      (s_valid_i),
        .in_ready_o      (s_ready_o),
        .in_word_i       (tagger_pkg::tag_word_t'(s_data_i)),
        .out_valid_o     (dec_valid),
        .out_ready_i     (dec_ready),
        .out_tag_o       (dec_tag),
        .overflow_o      (overflow_o),
        .invalid_count_o (invalid_count_o)
    );

    pipe_stage #(
        .payload_t(tagger_pkg::decoded_tag_t)
    ) dec_stage (
        .sys_clk     (sys_clk),
        .sys_clk_rst (sys_clk_rst),
        .in_valid_i  (dec_valid),
        .in_ready_o  (dec_ready),
        .in_data_i   (dec_tag),
        .out_valid_o (ext_in_valid),
        .out_ready_i (ext_in_ready),
        .out_data_o  (ext_in_tag)
    );

    tag_time_extender tag_time_extender_inst (
        .sys_clk     (sys_clk),
        .sys_clk_rst (sys_clk_rst),
        .in_valid_i  (ext_in_valid),
        .in_ready_o  (ext_in_ready),
        .in_tag_i    (ext_in_tag),
        .out_valid_o (ext_valid),
        .out_ready_i (ext_ready),
        .out_tag_o   (ext_tag)
    );

    pipe_stage #(
        .payload_t(tagger_pkg::timed_tag_t)
    ) out_stage (
        .sys_clk     (sys_clk),
        .sys_clk_rst (sys_clk_rst),
        .in_valid_i  (ext_valid),
        .in_ready_o  (ext_ready),
        .in_data_i   (ext_tag),
        .out_valid_o (m_valid_o),
        .out_ready_i (m_ready_i),
        .out_data_o  (out_tag)
    );

    assign m_channel_o = out_tag.channel;
    assign m_rising_o  = out_tag.rising;
    assign m_tagtime_o = out_tag.tagtime;

    // Counters see only beats that actually leave the design
    assign out_fire = m_valid_o && m_ready_i;

    channel_counters #(
        .NUM_CHANNELS(NUM_CHANNELS),
        .CNT_W       (CNT_W)
    ) channel_counters_inst (
        .sys_clk       (sys_clk),
        .sys_clk_rst   (sys_clk_rst),
        .evt_valid_i   (out_fire),
        .evt_channel_i (out_tag.channel),
        .evt_rising_i  (out_tag.rising),
        .clear_i       (cnt_clear_i),
        .rd_addr_i     (cnt_addr_i),
        .rd_data_o     (cnt_data_o)
    );

endmodule

//--- dv/tag_pipeline_checker.sv
`timescale 1ns/1ns

module tag_pipeline_checker (
    input logic        sys_clk,
    input logic        sys_clk_rst,
    input logic        s_valid_i,
    input logic        s_ready_o,
    input logic [31:0] s_data_i,
    input logic        m_valid_o,
    input logic        m_ready_i,
    input logic [4:0]  m_channel_o,
    input logic        m_rising_o,
    input logic [63:0] m_tagtime_o
);

    // A stalled word must wait unchanged on the input stream
    assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        s_valid_i && !s_ready_o |=> s_valid_i && $stable(s_data_i))
        else $error("Input word changed or was withdrawn while stalled");

    // Same rule for the timed event stream
    assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_channel_o)
            && $stable(m_rising_o) && $stable(m_tagtime_o))
        else $error("Output event changed or was withdrawn while stalled");

    assert property (@(posedge sys_clk) sys_clk_rst |=> !m_valid_o)
        else $error("Output valid is high right after reset");

    // Both stages are empty after reset, so the input side is open
    assert property (@(posedge sys_clk) sys_clk_rst |=> s_ready_o)
        else $error("Input ready is low right after reset");

endmodule

bind tag_pipeline_top tag_pipeline_checker tag_pipeline_checker_inst (
    .sys_clk     (sys_clk),
    .sys_clk_rst (sys_clk_rst),
    .s_valid_i   (s_valid_i),
    .s_ready_o   (s_ready_o),
    .s_data_i    (s_data_i),
    .m_valid_o   (m_valid_o),
    .m_ready_i   (m_ready_i),
    .m_channel_o (m_channel_o),
    .m_rising_o  (m_rising_o),
    .m_tagtime_o (m_tagtime_o)
);

//--- dv/tag_pipeline_tb.sv
`timescale 1ns/1ns

module tag_pipeline_tb;

    localparam int NUM_CHANNELS = 8;
    localparam int CNT_W        = 16;

    logic             sys_clk;
    logic             sys_clk_rst;
    logic             s_valid_i;
    logic             s_ready_o;
    logic [31:0]      s_data_i;
    logic             m_valid_o;
    logic             m_ready_i;
    logic [4:0]       m_channel_o;
    logic             m_rising_o;
    logic [63:0]      m_tagtime_o;
    logic [4:0]       cnt_addr_i;
    logic             cnt_clear_i;
    logic [CNT_W-1:0] cnt_data_o;
    logic             overflow_o;
    logic [15:0]      invalid_count_o;

    // Stimulus table with expected results
    string       row_name [$];
    logic [31:0] row_word [$];
    logic        row_exp_out [$];
    logic [4:0]  row_exp_channel [$];
    logic        row_exp_rising [$];
    logic [63:0] row_exp_tagtime [$];

    // Scoreboard holds row index and accept time of each beat in flight
    int          exp_row [$];
    time         exp_accept [$];

    // Reference model
    longint      model_wraps;
    int          model_rising [NUM_CHANNELS];
    int          model_invalid;
    logic        model_overflow;

    logic [31:0] lcg_state;
    logic        random_bp;
    logic        table_ready;
    int          random_start;

    tag_pipeline_top #(
        .NUM_CHANNELS(NUM_CHANNELS),
        .CNT_W       (CNT_W)
    ) tag_pipeline_top_inst (.*);

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Classify by channel code and predict the tagtime from the wrap count
    function automatic void add_row(string name, logic [4:0] chan, logic rising,
                                    logic [25:0] subtime);
        logic fwd;
        fwd = 1'b0;
        if (chan == 5'd31) begin
            model_wraps = model_wraps + 1;
        end else if (chan == 5'd30) begin
            model_overflow = 1'b1;
        end else if (int'(chan) >= NUM_CHANNELS) begin
            model_invalid = model_invalid + 1;
        end else begin
            fwd = 1'b1;
            if (rising) begin
                model_rising[chan] = model_rising[chan] + 1;
            end
        end
        row_name.push_back(name);
        row_word.push_back({chan, rising, subtime});
        row_exp_out.push_back(fwd);
        row_exp_channel.push_back(chan);
        row_exp_rising.push_back(rising);
        row_exp_tagtime.push_back(64'(model_wraps) * 64'd67108864 + 64'(subtime));
    endfunction

    task automatic report_failure(string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        assert (expected === actual)
        else begin
            report_failure($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                                     name, expected, actual));
        end
    endtask

    task automatic run_rows(int first, int last);
        for (int i = first; i < last; i++) begin
            @(negedge sys_clk);
            s_valid_i = 1'b1;
            s_data_i  = row_word[i];
            @(posedge sys_clk);
            while (!s_ready_o) begin
                @(posedge sys_clk);
            end
            if (row_exp_out[i]) begin
                exp_row.push_back(i);
                exp_accept.push_back($time);
            end
        end
        @(negedge sys_clk);
        s_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_row.size() != 0) begin
            @(posedge sys_clk);
        end
        repeat (4) @(posedge sys_clk);
    endtask

    task automatic read_counter(logic [4:0] addr, int expected);
        @(negedge sys_clk);
        cnt_addr_i = addr;
        @(negedge sys_clk);
        check_value($sformatf("counter %0d", addr), 64'(expected % (1 << CNT_W)),
                    64'(cnt_data_o));
    endtask

    // Back-pressure changes on the falling edge only
    always @(negedge sys_clk) begin
        if (random_bp) begin
            void'(lcg_next());
            m_ready_i = lcg_state[17];
        end else begin
            m_ready_i = 1'b1;
        end
    end

    always @(posedge sys_clk) begin
        if (!sys_clk_rst && m_valid_o && m_ready_i) begin
            assert (exp_row.size() != 0)
            else report_failure("An output event appeared that no input word produced");
            check_value({row_name[exp_row[0]], " channel"}, 64'(row_exp_channel[exp_row[0]]),
                        64'(m_channel_o));
            check_value({row_name[exp_row[0]], " rising"}, 64'(row_exp_rising[exp_row[0]]),
                        64'(m_rising_o));
            check_value({row_name[exp_row[0]], " tagtime"}, row_exp_tagtime[exp_row[0]],
                        m_tagtime_o);
            // Without back-pressure each event leaves two edges after it was taken
            if (exp_row[0] < random_start) begin
                check_value({row_name[exp_row[0]], " latency"}, 64'd20,
                            64'($time - exp_accept[0]));
            end
            void'(exp_row.pop_front());
            void'(exp_accept.pop_front());
        end
    end

    initial begin
        wait (table_ready);
        repeat (row_word.size() * 20 + 200) @(posedge sys_clk);
        $display("Timeout: the output events or counter reads did not finish in time");
        $display("=== FAIL ===");
        $fatal(1);
    end

    initial begin
        logic [31:0] r;
        sys_clk_rst = 1'b1;
        s_valid_i = 1'b0;
        s_data_i = '0;
        m_ready_i = 1'b1;
        cnt_addr_i = '0;
        cnt_clear_i = 1'b0;
        lcg_state = 32'haca9;
        random_bp = 1'b0;
        table_ready = 1'b0;
        model_wraps = 0;
        model_invalid = 0;
        model_overflow = 1'b0;
        foreach (model_rising[i]) model_rising[i] = 0;

        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            add_row($sformatf("event ch%0d", ch), 5'(ch), ch % 3 != 2, 26'(ch * 'h12345 + 'h10));
        end
        add_row("wrap 1", 5'd31, 1'b0, 26'd0);
        add_row("event after 1 wrap", 5'd2, 1'b1, 26'h3ffffff);
        add_row("wrap 2", 5'd31, 1'b0, 26'h155);
        add_row("wrap 3", 5'd31, 1'b1, 26'h0);
        add_row("event after 3 wraps", 5'd5, 1'b1, 26'h0);
        add_row("ch0 after 3 wraps", 5'd0, 1'b0, 26'h2aaaaaa);
        add_row("invalid ch8", 5'd8, 1'b1, 26'h1);
        add_row("invalid ch29", 5'd29, 1'b1, 26'h3c);
        add_row("overflow marker", 5'd30, 1'b0, 26'h0);
        add_row("event after overflow", 5'd7, 1'b1, 26'h77);
        add_row("invalid ch15", 5'd15, 1'b0, 26'h99);
        random_start = row_word.size();
        for (int i = 0; i < 30; i++) begin
            r = lcg_next();
            if (i % 7 == 6) begin
                add_row($sformatf("random wrap %0d", i), 5'd31, 1'b0, r[25:0]);
            end else begin
                add_row($sformatf("random %0d", i), 5'(r[31:24] % 10), r[20], r[25:0]);
            end
        end
        table_ready = 1'b1;

        repeat (2) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_clk_rst = 1'b0;

        // Status starts clear, so the overflow marker must be what sets it
        check_value("overflow after reset", 64'd0, 64'(overflow_o));
        check_value("invalid count after reset", 64'd0, 64'(invalid_count_o));

        run_rows(0, random_start);
        wait_drain();
        random_bp = 1'b1;
        run_rows(random_start, row_word.size());
        wait_drain();
        random_bp = 1'b0;

        check_value("invalid count", 64'(model_invalid), 64'(invalid_count_o));
        check_value("overflow flag", 64'(model_overflow), 64'(overflow_o));
        for (int a = 0; a < NUM_CHANNELS; a++) begin
            read_counter(5'(a), model_rising[a]);
        end
        read_counter(5'd20, 0);

        @(negedge sys_clk);
        cnt_clear_i = 1'b1;
        @(negedge sys_clk);
        cnt_clear_i = 1'b0;
        for (int a = 0; a < NUM_CHANNELS; a++) begin
            read_counter(5'(a), 0);
        end
        read_counter(5'd20, 0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- tag_pipeline_top.f
hw/tagger_pkg.sv
hw/pipe_stage.sv
hw/tag_decoder.sv
hw/tag_time_extender.sv
hw/channel_counters.sv
hw/tag_pipeline_top.sv
dv/tag_pipeline_checker.sv
dv/tag_pipeline_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tag_pipeline_tb
FILELIST = tag_pipeline_top.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = === FAIL ===
PASS_MSG = === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF -- "$(FAIL_MSG)" $(LOG) || ! grep -qF -- "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
